/* tb.f */
design/dh_pkg.sv
design/dh_mult_round.sv
design/dh_sincos.sv
design/dh_step_timer.sv
design/dh_sequencer.sv
design/dh_product_unit.sv
design/dh_apb_regs.sv
design/dh_link_top.sv
sim/dh_chk.sv
sim/dh_tb.sv

/* Makefile */
# Verilator build and run for the dh link stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module dh_tb -o dh_sim
	./obj_dir/dh_sim +verilator+error+limit+100 2>&1 | tee sim.log
	@grep -q "Test OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module dh_tb

clean:
	rm -rf obj_dir sim.log

/* sim/dh_tb.sv */
// directed testbench for one dh link stage with apb traffic against a fixed-point model
`timescale 1ns/1ns

module dh_tb;

	localparam int W = dh_pkg::WORD_W;
	localparam int F = dh_pkg::FRAC_W;
	localparam int N_RES = dh_pkg::N_RES;
	localparam int RUN_CYCLES = 17;
	// 16 quadrant, 20 random, 1 busy, 2 irq runs
	localparam int N_RUNS = 39;
	localparam int TIMEOUT_CYCLES = N_RUNS * 400 + 1000;
	localparam longint WRAP = 64'sd1 <<< W;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [dh_pkg::ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	int cycle_cnt = 0;
	int start_cyc;
	logic [31:0] lfsr_state = 32'h80ce;
	// expected t00 t01 t02 t03 t10 t11 t12 t13 t21 t22 t23
	longint exp_t [0:N_RES-1];

	dh_link_top dh_link_top_inst (
		.i_clk(clk), .i_arst_n(arst_n),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.o_irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			abort_run("simulation hung, cycle limit reached before the tests finished");
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// apb transfers start and end 1 ns after a rising edge
	task automatic apb_write(input logic [dh_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// mid access phase
		#2;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [dh_pkg::ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2;
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_ok(input string name, input logic [dh_pkg::ADDR_W-1:0] addr,
		input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check({name, " pslverr"}, 32'd0, 32'(err));
	endtask

	task automatic read_check(input string name, input logic [dh_pkg::ADDR_W-1:0] addr,
		input logic [31:0] expected);
		logic [31:0] rd;
		logic err;
		apb_read(addr, rd, err);
		check(name, expected, rd);
		check({name, " pslverr"}, 32'd0, 32'(err));
	endtask

	function automatic longint sext27(input logic [31:0] x);
		return longint'($signed(x[W-1:0]));
	endfunction

	// drop 8 fraction bits, round half up, wrap to a 27-bit word
	function automatic longint round_q8(input longint p);
		longint r;
		r = (p >>> F) + ((p >>> (F - 1)) & 1);
		r = r & (WRAP - 1);
		if (r >= WRAP / 2) begin
			r = r - WRAP;
		end
		return r;
	endfunction

	// first quadrant value v * (c1 - c3 * v^2)
	function automatic longint poly_f(input longint v);
		longint sq;
		longint cub;
		sq = round_q8(v * v);
		cub = round_q8(sq * dh_pkg::SIN_C3);
		return round_q8((dh_pkg::SIN_C1 - cub) * v);
	endfunction

	function automatic longint ref_sin(input logic [9:0] ang);
		longint u;
		longint f;
		u = longint'(ang[7:0]);
		// odd quadrants mirror the position
		f = poly_f(ang[8] ? dh_pkg::FIX_ONE - u : u);
		return ang[9] ? -f : f;
	endfunction

	function automatic longint ref_cos(input logic [9:0] ang);
		longint u;
		longint f;
		u = longint'(ang[7:0]);
		f = poly_f(ang[8] ? u : dh_pkg::FIX_ONE - u);
		// negative in quadrants 1 and 2
		return (ang[9] ^ ang[8]) ? -f : f;
	endfunction

	// exact values at quarter turns
	function automatic logic [31:0] axis_sin(input int q);
		return (q == 1) ? 32'd256 : (q == 3) ? 32'hFFFF_FF00 : 32'd0;
	endfunction

	function automatic logic [31:0] axis_cos(input int q);
		return (q == 0) ? 32'd256 : (q == 2) ? 32'hFFFF_FF00 : 32'd0;
	endfunction

	task automatic build_matrix(input logic [31:0] th, input logic [31:0] al,
		input logic [31:0] av, input logic [31:0] dv);
		longint st, ct, sa, ca, a_s;
		st = ref_sin(th[9:0]);
		ct = ref_cos(th[9:0]);
		sa = ref_sin(al[9:0]);
		ca = ref_cos(al[9:0]);
		a_s = sext27(av);
		exp_t[0] = ct;
		exp_t[1] = round_q8(-st * ca);
		exp_t[2] = round_q8(st * sa);
		exp_t[3] = round_q8(a_s * ct);
		exp_t[4] = st;
		exp_t[5] = round_q8(ct * ca);
		exp_t[6] = round_q8(-ct * sa);
		exp_t[7] = round_q8(a_s * st);
		exp_t[8] = sa;
		exp_t[9] = ca;
		exp_t[10] = sext27(dv);
	endtask

	task automatic set_params(input string name, input logic [31:0] th, input logic [31:0] al,
		input logic [31:0] av, input logic [31:0] dv);
		write_ok({name, " theta"}, dh_pkg::REG_THETA, th);
		write_ok({name, " alpha"}, dh_pkg::REG_ALPHA, al);
		write_ok({name, " a"}, dh_pkg::REG_A, av);
		write_ok({name, " d"}, dh_pkg::REG_D, dv);
	endtask

	task automatic start_run(input string name);
		write_ok({name, " start"}, dh_pkg::REG_CTRL, 32'd1);
		start_cyc = cycle_cnt;
	endtask

	// poll status until done within the run length
	task automatic wait_done(input string name);
		logic [31:0] status;
		logic err;
		int seen;
		status = '0;
		seen = 0;
		while (!status[1] && seen <= RUN_CYCLES + 4) begin
			apb_read(dh_pkg::REG_STATUS, status, err);
			// sampled one cycle before the read returns
			seen = cycle_cnt - start_cyc - 1;
		end
		check({name, " done status"}, 32'd2, status);
		check({name, " done in time"}, 32'd1, 32'(seen <= RUN_CYCLES));
	endtask

	task automatic compare_results(input string name);
		for (int i = 0; i < N_RES; i++) begin
			read_check($sformatf("%s t[%0d]", name, i),
				dh_pkg::REG_T_BASE + 8'(4 * i), 32'(exp_t[i]));
		end
	endtask

	task automatic run_link(input string name, input logic [31:0] th, input logic [31:0] al,
		input logic [31:0] av, input logic [31:0] dv);
		build_matrix(th, al, av, dv);
		set_params(name, th, al, av, dv);
		start_run(name);
		wait_done(name);
		compare_results(name);
		check({name, " irq"}, 32'd1, 32'(irq));
	endtask

	task automatic after_reset();
		check("reset irq", 32'd0, 32'(irq));
		read_check("reset ctrl", dh_pkg::REG_CTRL, 32'd0);
		read_check("reset status", dh_pkg::REG_STATUS, 32'd0);
		read_check("reset theta", dh_pkg::REG_THETA, 32'd0);
		read_check("reset alpha", dh_pkg::REG_ALPHA, 32'd0);
		read_check("reset a", dh_pkg::REG_A, 32'd0);
		read_check("reset d", dh_pkg::REG_D, 32'd0);
		for (int i = 0; i < N_RES; i++) begin
			read_check($sformatf("reset t[%0d]", i), dh_pkg::REG_T_BASE + 8'(4 * i), 32'd0);
		end
	endtask

	task automatic quadrant_sweep();
		string name;
		for (int qt = 0; qt < 4; qt++) begin
			for (int qa = 0; qa < 4; qa++) begin
				name = $sformatf("quad %0d %0d", qt, qa);
				// a of 3.0 with random d
				run_link(name, 32'(qt * 256), 32'(qa * 256), 32'(3 * dh_pkg::FIX_ONE),
					rand_bits(32));
				read_check({name, " t00"}, dh_pkg::REG_T_BASE, axis_cos(qt));
				read_check({name, " t10"}, dh_pkg::REG_T_BASE + 8'd16, axis_sin(qt));
				read_check({name, " t21"}, dh_pkg::REG_T_BASE + 8'd32, axis_sin(qa));
				read_check({name, " t22"}, dh_pkg::REG_T_BASE + 8'd36, axis_cos(qa));
			end
		end
	endtask

	task automatic random_sweep();
		logic [31:0] th, al, av, dv;
		for (int n = 0; n < 20; n++) begin
			// upper angle bits are don't care
			th = rand_bits(12);
			al = rand_bits(12);
			av = rand_bits(32);
			dv = rand_bits(32);
			run_link($sformatf("random %0d", n), th, al, av, dv);
			read_check($sformatf("random %0d a readback", n), dh_pkg::REG_A, 32'(sext27(av)));
		end
	endtask

	task automatic busy_refusal();
		logic [31:0] th, al, av, dv;
		logic err;
		th = rand_bits(10);
		al = rand_bits(10);
		av = rand_bits(32);
		dv = rand_bits(32);
		build_matrix(th, al, av, dv);
		set_params("busy", th, al, av, dv);
		start_run("busy");
		// all refused while the run is in flight
		apb_write(dh_pkg::REG_A, ~av, err);
		check("busy write a", 32'd1, 32'(err));
		apb_write(dh_pkg::REG_THETA, th + 32'd100, err);
		check("busy write theta", 32'd1, 32'(err));
		apb_write(dh_pkg::REG_CTRL, 32'd1, err);
		check("busy write ctrl", 32'd1, 32'(err));
		read_check("busy status", dh_pkg::REG_STATUS, 32'd1);
		read_check("busy a kept", dh_pkg::REG_A, 32'(sext27(av)));
		read_check("busy theta kept", dh_pkg::REG_THETA, th);
		wait_done("busy");
		compare_results("busy");
	endtask

	task automatic illegal_access();
		logic [31:0] rd;
		logic err;
		apb_read(8'h18, rd, err);
		check("unmapped read", 32'd1, 32'(err));
		// one word past t23
		apb_read(8'h4C, rd, err);
		check("past results read", 32'd1, 32'(err));
		apb_read(8'h22, rd, err);
		check("misaligned read", 32'd1, 32'(err));
		apb_write(dh_pkg::REG_STATUS, 32'h0, err);
		check("status write", 32'd1, 32'(err));
		read_check("status kept", dh_pkg::REG_STATUS, 32'd2);
		apb_write(dh_pkg::REG_T_BASE, 32'h1234, err);
		check("result write", 32'd1, 32'(err));
		read_check("t00 kept", dh_pkg::REG_T_BASE, 32'(exp_t[0]));
		// low address bits alias the d register
		apb_write(8'hF4, 32'hFFFF_FFFF, err);
		check("unmapped write", 32'd1, 32'(err));
		read_check("d kept", dh_pkg::REG_D, 32'(exp_t[10]));
		check("bad access irq", 32'd1, 32'(irq));
	endtask

	task automatic irq_cycle();
		run_link("irq first", 32'd100, 32'd700, 32'h0001_0000, 32'hFFFF_F000);
		read_check("irq status", dh_pkg::REG_STATUS, 32'd2);
		start_run("irq restart");
		// flag cleared on the start access itself
		check("irq cleared", 32'd0, 32'(irq));
		read_check("irq restart status", dh_pkg::REG_STATUS, 32'd1);
		wait_done("irq restart");
		check("irq set again", 32'd1, 32'(irq));
		compare_results("irq restart");
	endtask

	initial begin
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		after_reset();
		quadrant_sweep();
		random_sweep();
		busy_refusal();
		illegal_access();
		irq_cycle();
		check("bound assertions", 32'd0, 32'(dh_link_top_inst.link_chk_inst.fail_cnt));
		check("pready", 32'd1, 32'(pready));
		$display("Test OK");
		$finish;
	end

endmodule

/* sim/dh_chk.sv */
// bound assertions on the apb side and the link run sequencing
`timescale 1ns/1ns

module dh_chk (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_pready,
	input  logic  i_busy,
	input  logic  i_done,
	input  logic  i_irq,
	input  logic  i_start
);

	// start access to done flag, in clock edges
	localparam int RUN_CYCLES = 17;

	// read back by the testbench at the end of the run
	int fail_cnt = 0;

	// zero wait states on every transfer
	pready_high: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_pready)
		else begin
			$error("pready went low");
			fail_cnt++;
		end

	// done flag only while idle
	busy_done_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_busy && i_irq))
		else begin
			$error("busy and done set together");
			fail_cnt++;
		end

	// irq is the done flag, set by the completion pulse, cleared by start
	irq_set: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_done |=> i_irq)
		else begin
			$error("irq not set after completion");
			fail_cnt++;
		end
	irq_clear: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_start |=> !i_irq)
		else begin
			$error("irq not cleared by start");
			fail_cnt++;
		end

	// fixed run length
	done_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(i_irq) |-> $past(i_start, RUN_CYCLES))
		else begin
			$error("done did not rise 17 cycles after start");
			fail_cnt++;
		end

endmodule

bind dh_link_top dh_chk link_chk_inst (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_pready(o_pready),
	.i_busy(busy),
	.i_done(done),
	.i_irq(o_irq),
	.i_start(start_req)
);

/* design/dh_link_top.sv */
// one dh link stage with apb registers around the sincos and product datapath
`timescale 1ns/1ns

module dh_link_top (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic                              i_psel,
	input  logic                              i_penable,
	input  logic                              i_pwrite,
	input  logic        [dh_pkg::ADDR_W-1:0]  i_paddr,
	input  logic        [dh_pkg::DATA_W-1:0]  i_pwdata,
	output logic        [dh_pkg::DATA_W-1:0]  o_prdata,
	output logic                              o_pready,
	output logic                              o_pslverr,
	output logic                              o_irq
);

	localparam int W = dh_pkg::WORD_W;

	logic start_req, busy, done;
	logic [W-1:0] theta, alpha, a, sc_angle;
	logic sc_valid, sc_sel_alpha, theta_ready, alpha_ready;
	logic signed [W-1:0] sin_theta, cos_theta, sin_alpha, cos_alpha;
	logic tmr_load, tmr_expired;
	logic [dh_pkg::CNT_W-1:0] tmr_load_val, tmr_index;
	logic prod_issue, prod_valid;
	logic [dh_pkg::CNT_W-1:0] prod_index;
	logic signed [W-1:0] prod;

	// angle steered by the issue select
	assign sc_angle = sc_sel_alpha ? alpha : theta;

	dh_apb_regs apb_regs_inst (.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite), .i_paddr(i_paddr),
		.i_pwdata(i_pwdata), .o_prdata(o_prdata), .o_pready(o_pready),
		.o_pslverr(o_pslverr), .i_busy(busy), .i_done(done), .i_prod_valid(prod_valid),
		.i_prod_index(prod_index), .i_prod(prod), .i_sin_theta(sin_theta),
		.i_cos_theta(cos_theta), .i_sin_alpha(sin_alpha), .i_cos_alpha(cos_alpha),
		.o_start(start_req), .o_theta(theta), .o_alpha(alpha), .o_a(a), .o_d(),
		.o_irq(o_irq));

	dh_sequencer sequencer_inst (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(start_req),
		.i_expired(tmr_expired), .i_index(tmr_index), .i_alpha_ready(alpha_ready),
		.o_sc_valid(sc_valid), .o_sc_sel_alpha(sc_sel_alpha), .o_load(tmr_load),
		.o_load_val(tmr_load_val), .o_prod_valid(prod_issue), .o_busy(busy), .o_done(done));

	dh_step_timer step_timer_inst (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_load(tmr_load),
		.i_load_val(tmr_load_val), .o_expired(tmr_expired), .o_index(tmr_index));

	dh_sincos sincos_inst (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_valid(sc_valid),
		.i_sel_alpha(sc_sel_alpha), .i_angle(sc_angle), .o_sin_theta(sin_theta),
		.o_cos_theta(cos_theta), .o_sin_alpha(sin_alpha), .o_cos_alpha(cos_alpha),
		.o_theta_ready(theta_ready), .o_alpha_ready(alpha_ready));

	dh_product_unit product_unit_inst (.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_valid(prod_issue), .i_index(tmr_index), .i_a(a), .i_sin_theta(sin_theta),
		.i_cos_theta(cos_theta), .i_sin_alpha(sin_alpha), .i_cos_alpha(cos_alpha),
		.i_theta_ready(theta_ready), .i_alpha_ready(alpha_ready), .o_valid(prod_valid),
		.o_index(prod_index), .o_p(prod));

endmodule

/* design/dh_apb_regs.sv */
// apb3 slave with link parameters, result matrix, status and interrupt
`timescale 1ns/1ns

module dh_apb_regs (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic                              i_psel,
	input  logic                              i_penable,
	input  logic                              i_pwrite,
	input  logic        [dh_pkg::ADDR_W-1:0]  i_paddr,
	input  logic        [dh_pkg::DATA_W-1:0]  i_pwdata,
	output logic        [dh_pkg::DATA_W-1:0]  o_prdata,
	output logic                              o_pready,
	output logic                              o_pslverr,
	input  logic                              i_busy,
	input  logic                              i_done,
	input  logic                              i_prod_valid,
	input  logic        [dh_pkg::CNT_W-1:0]   i_prod_index,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_prod,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_sin_theta,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_cos_theta,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_sin_alpha,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_cos_alpha,
	output logic                              o_start,
	output logic        [dh_pkg::WORD_W-1:0]  o_theta,
	output logic        [dh_pkg::WORD_W-1:0]  o_alpha,
	output logic        [dh_pkg::WORD_W-1:0]  o_a,
	output logic        [dh_pkg::WORD_W-1:0]  o_d,
	output logic                              o_irq
);

	localparam int W = dh_pkg::WORD_W;
	localparam int DW = dh_pkg::DATA_W;
	localparam int AW = dh_pkg::ADDR_W;
	localparam int NR = dh_pkg::N_RES;

	logic access, wr;
	logic sel_ctrl, sel_status, sel_param, sel_res;
	logic [AW-1:0] res_off;
	logic [3:0] res_idx;
	logic [3:0] prod_slot;
	logic done_q;
	logic [W-1:0] res_q [0:NR-1];
	logic [W-1:0] rd_word;

	assign access = i_psel & i_penable;
	assign wr = access & i_pwrite;

	// address decode, word aligned only
	assign res_off = i_paddr - dh_pkg::REG_T_BASE;
	assign res_idx = res_off[5:2];
	assign sel_ctrl = (i_paddr == dh_pkg::REG_CTRL);
	assign sel_status = (i_paddr == dh_pkg::REG_STATUS);
	assign sel_param = (i_paddr == dh_pkg::REG_THETA) || (i_paddr == dh_pkg::REG_ALPHA) ||
		(i_paddr == dh_pkg::REG_A) || (i_paddr == dh_pkg::REG_D);
	assign sel_res = (i_paddr >= dh_pkg::REG_T_BASE) && (res_off[1:0] == 2'b00) &&
		(res_off < AW'(4 * NR));

	// unmapped, read-only, or busy parameter write
	assign o_pslverr = access & (~(sel_ctrl | sel_status | sel_param | sel_res) |
		(i_pwrite & (sel_status | sel_res)) |
		(i_pwrite & i_busy & (sel_ctrl | sel_param)));
	assign o_pready = 1'b1;

	assign o_start = wr & sel_ctrl & ~i_busy & i_pwdata[0];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_theta <= '0;
			o_alpha <= '0;
			o_a <= '0;
			o_d <= '0;
		end else if (wr & ~i_busy) begin
			case (i_paddr)
				dh_pkg::REG_THETA: o_theta <= i_pwdata[W-1:0];
				dh_pkg::REG_ALPHA: o_alpha <= i_pwdata[W-1:0];
				dh_pkg::REG_A: o_a <= i_pwdata[W-1:0];
				dh_pkg::REG_D: o_d <= i_pwdata[W-1:0];
				default: ;
			endcase
		end
	end

	// products 0..2 go to t01..t03, 3..5 to t11..t13
	assign prod_slot = (i_prod_index < 4'd3) ? i_prod_index + 4'd1 : i_prod_index + 4'd2;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < NR; i++) begin
				res_q[i] <= '0;
			end
		end else begin
			if (i_prod_valid) begin
				res_q[prod_slot] <= i_prod;
			end
			// angle terms and d at completion
			if (i_done) begin
				res_q[0] <= i_cos_theta;
				res_q[4] <= i_sin_theta;
				res_q[8] <= i_sin_alpha;
				res_q[9] <= i_cos_alpha;
				res_q[10] <= o_d;
			end
		end
	end

	// done set at completion, cleared by the next start
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			done_q <= 1'b0;
		end else if (i_done) begin
			done_q <= 1'b1;
		end else if (o_start) begin
			done_q <= 1'b0;
		end
	end

	assign o_irq = done_q;

	// read mux
	always_comb begin
		rd_word = '0;
		case (i_paddr)
			dh_pkg::REG_STATUS: rd_word = W'({done_q, i_busy});
			dh_pkg::REG_THETA: rd_word = o_theta;
			dh_pkg::REG_ALPHA: rd_word = o_alpha;
			dh_pkg::REG_A: rd_word = o_a;
			dh_pkg::REG_D: rd_word = o_d;
			default: rd_word = sel_res ? res_q[res_idx] : '0;
		endcase
	end

	// sign extend to the bus, status bits are non-negative
	assign o_prdata = (access & ~i_pwrite) ? {{(DW-W){rd_word[W-1]}}, rd_word} : '0;

endmodule

/* design/dh_product_unit.sv */
// operand select and shared multiplier for the six matrix products
`timescale 1ns/1ns

module dh_product_unit (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic                              i_valid,
	input  logic        [dh_pkg::CNT_W-1:0]   i_index,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_a,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_sin_theta,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_cos_theta,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_sin_alpha,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_cos_alpha,
	input  logic                              i_theta_ready,
	input  logic                              i_alpha_ready,
	output logic                              o_valid,
	output logic        [dh_pkg::CNT_W-1:0]   o_index,
	output logic signed [dh_pkg::WORD_W-1:0]  o_p
);

	localparam int W = dh_pkg::WORD_W;
	localparam int LAT = dh_pkg::MUL_LAT;

	logic signed [W-1:0] st_q, ct_q, sa_q, ca_q;
	logic signed [W-1:0] op_a, op_b;
	logic [LAT-1:0] valid_d;
	logic [dh_pkg::CNT_W-1:0] index_d [0:LAT-1];

	// angle values captured as they leave the sincos pipe
	always_ff @(posedge i_clk) begin
		if (i_theta_ready) begin
			st_q <= i_sin_theta;
			ct_q <= i_cos_theta;
		end
		if (i_alpha_ready) begin
			sa_q <= i_sin_alpha;
			ca_q <= i_cos_alpha;
		end
	end

	// t01 t02 t03 t11 t12 t13
	always_comb begin
		case (i_index)
			4'd0: begin op_a = -st_q; op_b = ca_q; end
			4'd1: begin op_a = st_q; op_b = sa_q; end
			4'd2: begin op_a = i_a; op_b = ct_q; end
			4'd3: begin op_a = ct_q; op_b = ca_q; end
			4'd4: begin op_a = -ct_q; op_b = sa_q; end
			default: begin op_a = i_a; op_b = st_q; end
		endcase
	end

	dh_mult_round prod_mult (.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_a(op_a), .i_b(op_b), .o_p(o_p));

	// index and valid ride alongside the multiplier
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_d <= '0;
			for (int i = 0; i < LAT; i++) begin
				index_d[i] <= '0;
			end
		end else begin
			valid_d <= {valid_d[LAT-2:0], i_valid};
			index_d[0] <= i_index;
			for (int i = 1; i < LAT; i++) begin
				index_d[i] <= index_d[i-1];
			end
		end
	end

	assign o_valid = valid_d[LAT-1];
	assign o_index = index_d[LAT-1];

endmodule

/* design/dh_sequencer.sv */
// link sequencer fsm, steers angle issue, product issue and completion
`timescale 1ns/1ns

module dh_sequencer (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_start,
	input  logic                       i_expired,
	input  logic [dh_pkg::CNT_W-1:0]   i_index,
	input  logic                       i_alpha_ready,
	output logic                       o_sc_valid,
	output logic                       o_sc_sel_alpha,
	output logic                       o_load,
	output logic [dh_pkg::CNT_W-1:0]   o_load_val,
	output logic                       o_prod_valid,
	output logic                       o_busy,
	output logic                       o_done
);

	localparam int CW = dh_pkg::CNT_W;

	typedef enum logic [2:0] {
		IDLE,
		ISSUE_THETA,
		ISSUE_ALPHA,
		WAIT_ANGLES,
		PRODUCTS,
		DRAIN
	} state_t;

	state_t state_q;
	state_t state_d;
	logic last_prod;

	assign last_prod = (i_index == CW'(dh_pkg::N_PROD - 1));

	always_comb begin
		state_d = state_q;
		o_load = 1'b0;
		o_load_val = '0;
		case (state_q)
			IDLE: begin
				if (i_start) begin
					state_d = ISSUE_THETA;
				end
			end
			ISSUE_THETA: begin
				state_d = ISSUE_ALPHA;
			end
			ISSUE_ALPHA: begin
				state_d = WAIT_ANGLES;
			end
			WAIT_ANGLES: begin
				// timer index becomes product number
				if (i_alpha_ready) begin
					o_load = 1'b1;
					o_load_val = CW'(dh_pkg::N_PROD - 1);
					state_d = PRODUCTS;
				end
			end
			PRODUCTS: begin
				// let the last products leave the multiplier
				if (last_prod) begin
					o_load = 1'b1;
					o_load_val = CW'(dh_pkg::MUL_LAT - 1);
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				if (i_expired) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign o_sc_valid = (state_q == ISSUE_THETA) || (state_q == ISSUE_ALPHA);
	assign o_sc_sel_alpha = (state_q == ISSUE_ALPHA);
	assign o_prod_valid = (state_q == PRODUCTS);
	assign o_busy = (state_q != IDLE);
	// last drain cycle, registered as done by the register block
	assign o_done = (state_q == DRAIN) && i_expired;

endmodule

/* design/dh_step_timer.sv */
// loadable down-counter with an up-counting step index
`timescale 1ns/1ns

module dh_step_timer (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_load,
	input  logic [dh_pkg::CNT_W-1:0]   i_load_val,
	output logic                       o_expired,
	output logic [dh_pkg::CNT_W-1:0]   o_index
);

	logic [dh_pkg::CNT_W-1:0] cnt_q;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt_q <= '0;
			o_index <= '0;
		end else if (i_load) begin
			cnt_q <= i_load_val;
			o_index <= '0;
		end else begin
			// hold at zero once run out
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			o_index <= o_index + 1'b1;
		end
	end

	assign o_expired = (cnt_q == '0);

endmodule

/* design/dh_sincos.sv */
// pipelined sine and cosine, quadrant folding around a cubic polynomial
`timescale 1ns/1ns

module dh_sincos (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic                              i_valid,
	input  logic                              i_sel_alpha,
	input  logic        [dh_pkg::WORD_W-1:0]  i_angle,
	output logic signed [dh_pkg::WORD_W-1:0]  o_sin_theta,
	output logic signed [dh_pkg::WORD_W-1:0]  o_cos_theta,
	output logic signed [dh_pkg::WORD_W-1:0]  o_sin_alpha,
	output logic signed [dh_pkg::WORD_W-1:0]  o_cos_alpha,
	output logic                              o_theta_ready,
	output logic                              o_alpha_ready
);

	localparam int W = dh_pkg::WORD_W;
	localparam int LAT = dh_pkg::SINCOS_LAT;
	localparam int VD = 2 * dh_pkg::MUL_LAT;
	localparam logic signed [W-1:0] C1 = W'(dh_pkg::SIN_C1);
	localparam logic signed [W-1:0] C3 = W'(dh_pkg::SIN_C3);

	logic [1:0] quad;
	logic [dh_pkg::QUAD_W-1:0] u;
	logic [dh_pkg::QUAD_W:0] u_rev;
	// chain 0 is sine, chain 1 is cosine
	logic signed [W-1:0] v_in [0:1];
	logic signed [W-1:0] v_d [0:1][0:VD-1];
	logic signed [W-1:0] f [0:1];
	// side band travelling with the data
	logic [1:0] quad_d [0:LAT-1];
	logic [LAT-1:0] tag_d;
	logic [LAT-1:0] valid_d;
	logic signed [W-1:0] sin_new;
	logic signed [W-1:0] cos_new;
	logic signed [W-1:0] sin_t_q, cos_t_q, sin_a_q, cos_a_q;

	assign quad = i_angle[dh_pkg::ANGLE_W-1 -: 2];
	assign u = i_angle[dh_pkg::QUAD_W-1:0];
	assign u_rev = (dh_pkg::QUAD_W+1)'(dh_pkg::FIX_ONE) - {1'b0, u};

	// odd quadrants swap the two positions
	assign v_in[0] = quad[0] ? W'(u_rev) : W'(u);
	assign v_in[1] = quad[0] ? W'(u) : W'(u_rev);

	for (genvar ch = 0; ch < 2; ch++) begin : g_chain
		logic signed [W-1:0] sq;
		logic signed [W-1:0] cub;
		logic signed [W-1:0] diff;

		// v squared
		dh_mult_round sq_mult (.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_a(v_in[ch]), .i_b(v_in[ch]), .o_p(sq));
		// c3 * v^2
		dh_mult_round c3_mult (.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_a(sq), .i_b(C3), .o_p(cub));
		assign diff = C1 - cub;
		// times v, delayed to line up
		dh_mult_round v_mult (.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_a(diff), .i_b(v_d[ch][VD-1]), .o_p(f[ch]));

		always_ff @(posedge i_clk) begin
			v_d[ch][0] <= v_in[ch];
			for (int i = 1; i < VD; i++) begin
				v_d[ch][i] <= v_d[ch][i-1];
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_d <= '0;
			tag_d <= '0;
			for (int i = 0; i < LAT; i++) begin
				quad_d[i] <= '0;
			end
		end else begin
			valid_d <= {valid_d[LAT-2:0], i_valid};
			tag_d <= {tag_d[LAT-2:0], i_sel_alpha};
			quad_d[0] <= quad;
			for (int i = 1; i < LAT; i++) begin
				quad_d[i] <= quad_d[i-1];
			end
		end
	end

	// sine negative in quadrants 2 and 3, cosine in 1 and 2
	assign sin_new = quad_d[LAT-1][1] ? -f[0] : f[0];
	assign cos_new = (quad_d[LAT-1][1] ^ quad_d[LAT-1][0]) ? -f[1] : f[1];

	assign o_theta_ready = valid_d[LAT-1] & ~tag_d[LAT-1];
	assign o_alpha_ready = valid_d[LAT-1] & tag_d[LAT-1];

	// hold the last result of each angle
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sin_t_q <= '0;
			cos_t_q <= '0;
			sin_a_q <= '0;
			cos_a_q <= '0;
		end else if (o_theta_ready) begin
			sin_t_q <= sin_new;
			cos_t_q <= cos_new;
		end else if (o_alpha_ready) begin
			sin_a_q <= sin_new;
			cos_a_q <= cos_new;
		end
	end

	// fresh value bypasses the hold on the capture cycle
	assign o_sin_theta = o_theta_ready ? sin_new : sin_t_q;
	assign o_cos_theta = o_theta_ready ? cos_new : cos_t_q;
	assign o_sin_alpha = o_alpha_ready ? sin_new : sin_a_q;
	assign o_cos_alpha = o_alpha_ready ? cos_new : cos_a_q;

endmodule

/* design/dh_mult_round.sv */
// two-stage signed multiplier, product rounded back to 8 fraction bits
`timescale 1ns/1ns

module dh_mult_round (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_a,
	input  logic signed [dh_pkg::WORD_W-1:0]  i_b,
	output logic signed [dh_pkg::WORD_W-1:0]  o_p
);

	localparam int W = dh_pkg::WORD_W;
	localparam int F = dh_pkg::FRAC_W;

	// full width product
	logic signed [2*W-1:0] prod_q;

	// stage 1
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			prod_q <= '0;
		end else begin
			prod_q <= i_a * i_b;
		end
	end

	// stage 2, drop fraction bits
	// round half up on the top dropped bit, wrap past 27 bits
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_p <= '0;
		end else begin
			o_p <= prod_q[W+F-1:F] + W'(prod_q[F-1]);
		end
	end

endmodule

/* design/dh_pkg.sv */
// dh link package: widths, fixed-point constants, latencies and register map
package dh_pkg;

	// data words, 27-bit two's complement with 8 fraction bits
	localparam int WORD_W = 27;
	localparam int FRAC_W = 8;
	localparam int FIX_ONE = 256;
	// apb data bus
	localparam int DATA_W = 32;

	// angles in 1/1024 turn
	localparam int ANGLE_W = 10;
	localparam int QUAD_W = 8;

	// first quadrant polynomial, f(v) = v * (c1 - c3 * v^2)
	localparam int SIN_C1 = 402;
	localparam int SIN_C3 = 146;

	// pipeline latencies
	localparam int MUL_LAT = 2;
	localparam int SINCOS_LAT = 6;

	// products and result words
	localparam int N_PROD = 6;
	localparam int N_RES = 11;
	localparam int CNT_W = 4;

	// register map
	localparam int ADDR_W = 8;
	localparam logic [ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [ADDR_W-1:0] REG_THETA = 8'h08;
	localparam logic [ADDR_W-1:0] REG_ALPHA = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_A = 8'h10;
	localparam logic [ADDR_W-1:0] REG_D = 8'h14;
	// t00 t01 t02 t03 t10 t11 t12 t13 t21 t22 t23
	localparam logic [ADDR_W-1:0] REG_T_BASE = 8'h20;

endpackage
